/* vlog.f */
src/ifu_pkg.sv
src/ifu_pcgen.sv
src/ifu_minidec.sv
src/ifu_ift2icb.sv
src/ifu_ir_stage.sv
src/ifu.sv
bench/ifu_properties.sv
bench/ifu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ifu_tb \
  -f vlog.f \
  -o Vifu_tb

out=$(./obj_dir/Vifu_tb)
echo "$out"

# Pass only if the testbench printed the pass line
echo "$out" | grep -qx "TEST PASS"

/* bench/ifu_tb.sv */
/*
  Fetch unit testbench
  Two bus memory models with random ready and latency, a reference
  next-PC function, and a compare process on every accepted entry.
  Runs the fetch stream, flush, misaligned flush and halt tests
*/
`timescale 1ns/1ps
`default_nettype none

// Single-outstanding bus memory, response delay 0 to 3 cycles
module bus_mem (
  input  wire logic        clk,
  input  wire logic [31:0] rnd,        // Random bits for this cycle
  input  wire logic        cmd_valid,
  output logic             cmd_ready,
  input  wire logic [31:0] cmd_addr,
  output logic             rsp_valid,
  input  wire logic        rsp_ready,
  output logic [31:0]      rsp_addr    // Address of the word returned
);
  logic        busy;
  logic [1:0]  dly;
  logic        cmd_hs;
  logic        rsp_hs;
  logic [31:0] r;

  initial begin
    cmd_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_addr  = '0;
    busy      = 1'b0;
    dly       = '0;
    forever begin
      @(negedge clk);  // Handshakes seen mid-cycle
      cmd_hs = cmd_valid && cmd_ready;
      rsp_hs = rsp_valid && rsp_ready;
      r      = rnd;
      @(posedge clk);
      #2;
      if (rsp_hs) begin
        rsp_valid = 1'b0;
        busy      = 1'b0;
      end
      if (cmd_hs) begin
        busy     = 1'b1;
        rsp_addr = cmd_addr;
        dly      = r[1:0];
      end
      if (busy && !rsp_valid) begin
        if (dly == 2'd0) rsp_valid = 1'b1;
        else dly = dly - 2'd1;
      end
      cmd_ready = (r[3:2] != 2'd0);  // Ready 3 cycles in 4
    end
  end
endmodule

module ifu_tb;

  localparam ifu_pkg::pc_t PC_RTVEC  = 32'h8000_0000;  // Also ITCM base
  localparam ifu_pkg::pc_t SYS_BASE  = 32'h2000_0000;
  localparam ifu_pkg::pc_t ERR_ADDR  = 32'h2000_0004;  // Faulting word
  localparam int           N_EXPECT  = 73;             // 40 + 20 + 1 + 4 + 8 entries

  logic                  clk;
  logic                  arst_n;
  logic [31:0]           rnd_state;
  logic                  itcm_cmd_valid, itcm_cmd_ready, itcm_rsp_valid, itcm_rsp_ready;
  logic [15:0]           itcm_cmd_addr;
  logic [31:0]           itcm_rsp_addr;
  logic                  biu_cmd_valid, biu_cmd_ready, biu_rsp_valid, biu_rsp_ready;
  ifu_pkg::pc_t          biu_cmd_addr;
  logic [31:0]           biu_rsp_addr;
  logic                  ifu_o_valid, ifu_o_ready, ifu_o_misalgn, ifu_o_buserr;
  logic                  ifu_o_prdt_taken;
  ifu_pkg::instr_t       ifu_o_ir;
  ifu_pkg::pc_t          ifu_o_pc;
  ifu_pkg::rfidx_t       ifu_o_rs1idx, ifu_o_rs2idx;
  logic                  pipe_flush_req, pipe_flush_ack, ifu_halt_req, ifu_halt_ack;
  ifu_pkg::pc_t          flush_op1, flush_op2;
  ifu_pkg::xlen_t        x1_val;
  int                    errors, checks, tests, acc_cnt, test_err0;
  string                 cur_test;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Program image, shared by both memories
  function automatic ifu_pkg::instr_t prog_word(input ifu_pkg::pc_t a);
    case (a)
      PC_RTVEC + 32'h0:  return 32'h0010_0093;  // addi x1,x0,1
      PC_RTVEC + 32'h4:  return 32'h0080_006f;  // jal x0,+8
      PC_RTVEC + 32'hc:  return 32'h0000_9463;  // bne x1,x0,+8 forward
      PC_RTVEC + 32'h10: return 32'h0000_8067;  // jalr x0,0(x1) to system memory
      SYS_BASE + 32'h8:  return 32'hfe00_9ce3;  // bne x1,x0,-8 backward
      default:           return {a[31:7] ^ a[24:0], 7'h13};  // Plain OP-IMM
    endcase
  endfunction

  function automatic logic addr_faults(input ifu_pkg::pc_t a);
    return a == ERR_ADDR;
  endfunction

  // Static prediction rules: JAL taken, backward Bxx taken, JALR via x0/x1
  function automatic ifu_pkg::pc_t ref_next_pc(input ifu_pkg::pc_t pc,
                                               input ifu_pkg::instr_t ir,
                                               input ifu_pkg::xlen_t x1);
    ifu_pkg::pc_t nxt;
    ifu_pkg::pc_t imm;
    nxt = pc + 32'd4;
    if (ir[6:0] == 7'b1101111) begin
      imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      nxt = pc + imm;
    end else if (ir[6:0] == 7'b1100011 && ir[31]) begin
      imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      nxt = pc + imm;
    end else if (ir[6:0] == 7'b1100111 && ir[19:16] == 4'd0) begin
      imm = {{20{ir[31]}}, ir[31:20]};
      nxt = ((ir[15] ? x1 : 32'd0) + imm) & ~32'd1;
    end
    return nxt;
  endfunction

  ifu ifu_i (
    .clk, .arst_n, .pc_rtvec(PC_RTVEC), .itcm_region_indic(PC_RTVEC),
    .itcm_cmd_valid, .itcm_cmd_ready, .itcm_cmd_addr, .itcm_rsp_valid, .itcm_rsp_ready,
    .itcm_rsp_err(addr_faults(itcm_rsp_addr)), .itcm_rsp_rdata(prog_word(itcm_rsp_addr)),
    .biu_cmd_valid, .biu_cmd_ready, .biu_cmd_addr, .biu_rsp_valid, .biu_rsp_ready,
    .biu_rsp_err(addr_faults(biu_rsp_addr)), .biu_rsp_rdata(prog_word(biu_rsp_addr)),
    .ifu_o_valid, .ifu_o_ready, .ifu_o_ir, .ifu_o_pc, .ifu_o_misalgn, .ifu_o_buserr,
    .ifu_o_prdt_taken, .ifu_o_rs1idx, .ifu_o_rs2idx, .rf2ifu_x1(x1_val),
    .pipe_flush_req, .pipe_flush_ack, .pipe_flush_add_op1(flush_op1),
    .pipe_flush_add_op2(flush_op2), .ifu_halt_req, .ifu_halt_ack
  );

  bus_mem itcm_mem (.clk, .rnd({16'd0, rnd_state[31:16]}), .cmd_valid(itcm_cmd_valid),
                    .cmd_ready(itcm_cmd_ready), .cmd_addr({PC_RTVEC[31:16], itcm_cmd_addr}),
                    .rsp_valid(itcm_rsp_valid), .rsp_ready(itcm_rsp_ready),
                    .rsp_addr(itcm_rsp_addr));
  bus_mem sys_mem (.clk, .rnd({16'd0, rnd_state[27:12]}), .cmd_valid(biu_cmd_valid),
                   .cmd_ready(biu_cmd_ready), .cmd_addr(biu_cmd_addr),
                   .rsp_valid(biu_rsp_valid), .rsp_ready(biu_rsp_ready),
                   .rsp_addr(biu_rsp_addr));

  //////////////////////////////
  // Clock, reset, random source
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns
  end

  initial begin
    rnd_state = 32'd3;  // Seed
    forever begin
      @(posedge clk);
      #1 rnd_state = lcg_next(rnd_state);
    end
  end

  // Execute unit back-pressure
  initial begin
    ifu_o_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2 ifu_o_ready = (rnd_state[29:28] != 2'd0);
    end
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      $display("[ERROR] %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // Compare accepted entries
  //////////////////////////////
  initial begin : compare
    ifu_pkg::pc_t    exp_pc;
    ifu_pkg::instr_t exp_ir;
    logic            stopped;  // After misaligned entry
    logic            mis;
    logic            err;
    exp_pc  = PC_RTVEC;
    stopped = 1'b0;
    forever begin
      @(negedge clk);
      if (ifu_o_valid && ifu_o_ready) begin
        checks++;
        assert (!stopped) else begin
          $display("%s: entry at %h delivered after a misaligned fetch", cur_test, ifu_o_pc);
          errors++;
        end
        mis    = |exp_pc[1:0];
        err    = addr_faults(exp_pc) && !mis;
        exp_ir = (mis || err) ? 32'd0 : prog_word(exp_pc);
        check_val("pc", exp_pc, ifu_o_pc);
        check_val("ir", exp_ir, ifu_o_ir);
        check_val("buserr", 32'(err), 32'(ifu_o_buserr));
        check_val("misalgn", 32'(mis), 32'(ifu_o_misalgn));
        check_val("taken", 32'(ref_next_pc(exp_pc, exp_ir, x1_val) != exp_pc + 32'd4),
                  32'(ifu_o_prdt_taken));
        check_val("rs1idx", 32'(exp_ir[19:15]), 32'(ifu_o_rs1idx));  // RV32 rs1 field
        check_val("rs2idx", 32'(exp_ir[24:20]), 32'(ifu_o_rs2idx));
        acc_cnt++;
        stopped = stopped || mis;
        exp_pc  = ref_next_pc(exp_pc, exp_ir, x1_val);
      end
      if (pipe_flush_req && pipe_flush_ack) begin  // Restart at flush target
        exp_pc  = flush_op1 + flush_op2;
        stopped = 1'b0;
      end
    end
  end

  // Runs at 2 ns after an edge
  task automatic wait_accepts(input int n);
    int target;
    target = acc_cnt + n;
    while (acc_cnt < target) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic do_flush(input ifu_pkg::pc_t op1, input ifu_pkg::pc_t op2);
    pipe_flush_req = 1'b1;
    flush_op1      = op1;
    flush_op2      = op2;
    do @(negedge clk); while (!pipe_flush_ack);
    @(posedge clk);
    #2 pipe_flush_req = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished with %0d errors", cur_test, errors - test_err0);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : main
    int n0;
    arst_n         = 1'b0;
    pipe_flush_req = 1'b0;
    ifu_halt_req   = 1'b0;
    flush_op1      = '0;
    flush_op2      = '0;
    x1_val         = SYS_BASE;  // JALR via x1 lands in system memory
    errors         = 0;
    checks         = 0;
    tests          = 0;
    acc_cnt        = 0;
    cur_test       = "reset";
    repeat (4) @(posedge clk);
    #2 arst_n = 1'b1;

    start_test("stream");  // ITCM, system memory, predictions, bus error
    wait_accepts(40);
    end_test();

    start_test("flush");
    do_flush(32'h8000_0080, 32'h0000_0080);
    wait_accepts(20);
    end_test();

    start_test("misalign");
    do_flush(32'h8000_0200, 32'd2);
    wait_accepts(1);
    repeat (20) begin
      @(posedge clk);
      #2;
    end
    do_flush(PC_RTVEC, 32'd0);
    wait_accepts(4);
    end_test();

    start_test("halt");
    ifu_halt_req = 1'b1;
    do @(negedge clk); while (!ifu_halt_ack);
    @(posedge clk);
    #2 n0 = acc_cnt + (ifu_o_valid ? 1 : 0);  // Entry already in IR may leave
    repeat (20) begin
      @(posedge clk);
      #2;
    end
    checks++;
    assert (acc_cnt <= n0) else begin
      $display("halt: new entry delivered while halt was acknowledged");
      errors++;
    end
    ifu_halt_req = 1'b0;
    wait_accepts(8);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized from the entry count
  initial begin
    repeat (200 * N_EXPECT) @(posedge clk);
    $display("watchdog: test %s did not finish in time", cur_test);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/ifu_properties.sv */
/*
  Fetch unit bus and execute handshake properties
  Bound to the fetch unit top level
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_properties #(
  parameter int ITCM_AW = ifu_pkg::ITCM_AW_DEFAULT
) (
  input wire logic               clk,
  input wire logic               arst_n,
  input wire logic               itcm_cmd_valid,
  input wire logic               itcm_cmd_ready,
  input wire logic [ITCM_AW-1:0] itcm_cmd_addr,
  input wire logic               biu_cmd_valid,
  input wire logic               biu_cmd_ready,
  input wire ifu_pkg::pc_t       biu_cmd_addr,
  input wire logic               ifu_o_valid,
  input wire logic               ifu_o_ready,
  input wire logic               pipe_flush_ack,
  input wire logic               ifu_halt_ack
);

  // Command held with stable address until ready
  itcm_cmd_stable: assert property (@(posedge clk) disable iff (!arst_n)
    itcm_cmd_valid && !itcm_cmd_ready |=> itcm_cmd_valid && $stable(itcm_cmd_addr))
    else $error("ITCM command dropped or changed before ready");
  biu_cmd_stable: assert property (@(posedge clk) disable iff (!arst_n)
    biu_cmd_valid && !biu_cmd_ready |=> biu_cmd_valid && $stable(biu_cmd_addr))
    else $error("system memory command dropped or changed before ready");

  one_port: assert property (@(posedge clk) !(itcm_cmd_valid && biu_cmd_valid))
    else $error("both bus commands valid");

  // Flush may clear the IR entry
  ir_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ifu_o_valid && !ifu_o_ready && !pipe_flush_ack |=> ifu_o_valid)
    else $error("IR entry lost before ready");

  reset_quiet: assert property (@(posedge clk) !arst_n |->
    !itcm_cmd_valid && !biu_cmd_valid && !ifu_o_valid && !pipe_flush_ack && !ifu_halt_ack)
    else $error("valid or ack high during reset");

endmodule

bind ifu ifu_properties #(.ITCM_AW(ITCM_AW)) props_i (.*);

`default_nettype wire

/* src/ifu.sv */
/*
  Instruction fetch unit, top level
  PC generation, fetch port to ITCM and system memory, mini-decode on
  the response path and the IR stage towards the execute unit
*/
`timescale 1ns/1ps
`default_nettype none

module ifu #(
  parameter int ITCM_AW = ifu_pkg::ITCM_AW_DEFAULT
) (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire ifu_pkg::pc_t    pc_rtvec,
  input  wire ifu_pkg::pc_t    itcm_region_indic,
  // ITCM bus
  output logic                 itcm_cmd_valid,
  input  wire logic            itcm_cmd_ready,
  output logic [ITCM_AW-1:0]   itcm_cmd_addr,
  input  wire logic            itcm_rsp_valid,
  output logic                 itcm_rsp_ready,
  input  wire logic            itcm_rsp_err,
  input  wire ifu_pkg::instr_t itcm_rsp_rdata,
  // System memory bus
  output logic                 biu_cmd_valid,
  input  wire logic            biu_cmd_ready,
  output ifu_pkg::pc_t         biu_cmd_addr,
  input  wire logic            biu_rsp_valid,
  output logic                 biu_rsp_ready,
  input  wire logic            biu_rsp_err,
  input  wire ifu_pkg::instr_t biu_rsp_rdata,
  // Execute unit
  output logic                 ifu_o_valid,
  input  wire logic            ifu_o_ready,
  output ifu_pkg::instr_t      ifu_o_ir,
  output ifu_pkg::pc_t         ifu_o_pc,
  output logic                 ifu_o_misalgn,
  output logic                 ifu_o_buserr,
  output logic                 ifu_o_prdt_taken,
  output ifu_pkg::rfidx_t      ifu_o_rs1idx,
  output ifu_pkg::rfidx_t      ifu_o_rs2idx,
  input  wire ifu_pkg::xlen_t  rf2ifu_x1,
  // Commit
  input  wire logic            pipe_flush_req,
  output logic                 pipe_flush_ack,
  input  wire ifu_pkg::pc_t    pipe_flush_add_op1,
  input  wire ifu_pkg::pc_t    pipe_flush_add_op2,
  input  wire logic            ifu_halt_req,
  output logic                 ifu_halt_ack
);

  logic                req_valid;
  logic                req_ready;
  ifu_pkg::fetch_req_t req;
  logic                cmd_pending;
  logic                fetch_idle;
  logic                rsp_valid;
  logic                rsp_done;
  ifu_pkg::fetch_rsp_t rsp;     // Fans out to pcgen, mini-decode, IR
  logic                ir_ready;
  ifu_pkg::prdt_t      prdt;
  ifu_pkg::rfidx_t     rs1idx;
  ifu_pkg::rfidx_t     rs2idx;
  logic                flush;

  assign flush = pipe_flush_req && pipe_flush_ack;  // Flush taken this cycle

  ifu_pcgen u_pcgen (.*);

  ifu_ift2icb #(.ITCM_AW(ITCM_AW)) u_ift2icb (.*);

  ifu_minidec u_minidec (.instr(rsp.instr), .pc(rsp.pc), .*);

  ifu_ir_stage u_ir_stage (.rsp_ready(ir_ready), .*);

endmodule

`default_nettype wire

/* src/ifu_ir_stage.sv */
/*
  IR stage
  One-entry register holding the fetched instruction, its PC, fault flags
  and the mini-decode result until the execute unit takes it
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_ir_stage (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                rsp_valid,
  input  wire ifu_pkg::fetch_rsp_t rsp,
  input  wire ifu_pkg::prdt_t      prdt,
  input  wire ifu_pkg::rfidx_t     rs1idx,
  input  wire ifu_pkg::rfidx_t     rs2idx,
  input  wire logic                flush,        // Clears the entry
  input  wire logic                ifu_o_ready,
  output logic                     rsp_ready,
  output logic                     ifu_o_valid,
  output ifu_pkg::instr_t          ifu_o_ir,
  output ifu_pkg::pc_t             ifu_o_pc,
  output logic                     ifu_o_misalgn,
  output logic                     ifu_o_buserr,
  output logic                     ifu_o_prdt_taken,
  output ifu_pkg::rfidx_t          ifu_o_rs1idx,
  output ifu_pkg::rfidx_t          ifu_o_rs2idx
);

  ifu_pkg::fetch_rsp_t ir_q;
  ifu_pkg::rfidx_t     rs1_q;
  ifu_pkg::rfidx_t     rs2_q;
  logic                taken_q;
  logic                valid_q;
  logic                load;

  // Empty, or emptied this cycle
  assign rsp_ready = !valid_q || ifu_o_ready;
  assign load      = rsp_valid && rsp_ready && !flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ifu_o_ready) begin
      valid_q <= 1'b0;  // Taken by execute unit
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      ir_q    <= rsp;
      taken_q <= prdt.taken;
      rs1_q   <= rs1idx;
      rs2_q   <= rs2idx;
    end
  end

  assign ifu_o_valid      = valid_q;
  assign ifu_o_ir         = ir_q.instr;
  assign ifu_o_pc         = ir_q.pc;
  assign ifu_o_misalgn    = ir_q.misalgn;
  assign ifu_o_buserr     = ir_q.buserr;
  assign ifu_o_prdt_taken = taken_q;
  assign ifu_o_rs1idx     = rs1_q;
  assign ifu_o_rs2idx     = rs2_q;

endmodule

`default_nettype wire

/* src/ifu_ift2icb.sv */
/*
  Fetch port
  Checks the request PC against the ITCM region, registers a read command
  on the ITCM or system memory bus and returns the response to the IR
  stage. One fetch in flight. Flushed responses are drained and dropped
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_ift2icb #(
  parameter int ITCM_AW = ifu_pkg::ITCM_AW_DEFAULT
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                req_valid,
  input  wire ifu_pkg::fetch_req_t req,
  input  wire logic                flush,          // Flush handshake
  input  wire logic                ir_ready,       // IR stage can take entry
  input  wire ifu_pkg::pc_t        itcm_region_indic,
  input  wire logic                itcm_cmd_ready,
  input  wire logic                itcm_rsp_valid,
  input  wire logic                itcm_rsp_err,
  input  wire ifu_pkg::instr_t     itcm_rsp_rdata,
  input  wire logic                biu_cmd_ready,
  input  wire logic                biu_rsp_valid,
  input  wire logic                biu_rsp_err,
  input  wire ifu_pkg::instr_t     biu_rsp_rdata,
  output logic                     req_ready,
  output logic                     cmd_pending,
  output logic                     fetch_idle,
  output logic                     rsp_valid,
  output logic                     rsp_done,
  output ifu_pkg::fetch_rsp_t      rsp,
  output logic                     itcm_cmd_valid,
  output logic [ITCM_AW-1:0]       itcm_cmd_addr,
  output logic                     itcm_rsp_ready,
  output logic                     biu_cmd_valid,
  output ifu_pkg::pc_t             biu_cmd_addr,
  output logic                     biu_rsp_ready
);

  typedef enum logic [1:0] {
    F_IDLE,  // Ready for a request
    F_CMD,   // Command on a bus
    F_RSP,   // Waiting for response
    F_MIS    // Misaligned, local response
  } fstate_t;

  fstate_t         state_q;
  logic            discard_q;   // Outstanding response was flushed
  logic            sel_itcm_q;  // Port of the fetch in flight
  ifu_pkg::pc_t    pc_q;
  logic            in_itcm;
  logic            req_fire;
  logic            cmd_valid;
  logic            cmd_hs;
  logic            port_cmd_ready;
  logic            port_rsp_valid;
  logic            port_rsp_ready;
  logic            port_rsp_err;
  logic            port_rsp_hs;
  ifu_pkg::instr_t port_rsp_rdata;

  //////////////////////////////
  // Request side
  //////////////////////////////
  assign in_itcm = (req.pc[ifu_pkg::PC_W-1:ITCM_AW]
                    == itcm_region_indic[ifu_pkg::PC_W-1:ITCM_AW]);
  assign fetch_idle = (state_q == F_IDLE);
  assign req_ready  = fetch_idle;  // Previous response must be gone
  assign req_fire   = req_valid && req_ready;

  //////////////////////////////
  // Bus side, steered by sel_itcm_q
  //////////////////////////////
  assign cmd_valid      = (state_q == F_CMD);
  assign itcm_cmd_valid = cmd_valid && sel_itcm_q;
  assign biu_cmd_valid  = cmd_valid && !sel_itcm_q;
  assign itcm_cmd_addr  = pc_q[ITCM_AW-1:0];
  assign biu_cmd_addr   = pc_q;
  assign port_cmd_ready = sel_itcm_q ? itcm_cmd_ready : biu_cmd_ready;
  assign cmd_hs         = cmd_valid && port_cmd_ready;
  assign cmd_pending    = cmd_valid && !port_cmd_ready;

  assign port_rsp_valid = sel_itcm_q ? itcm_rsp_valid : biu_rsp_valid;
  assign port_rsp_err   = sel_itcm_q ? itcm_rsp_err   : biu_rsp_err;
  assign port_rsp_rdata = sel_itcm_q ? itcm_rsp_rdata : biu_rsp_rdata;
  assign port_rsp_ready = (state_q == F_RSP) && (ir_ready || discard_q); // Drain if dropped
  assign itcm_rsp_ready = port_rsp_ready && sel_itcm_q;
  assign biu_rsp_ready  = port_rsp_ready && !sel_itcm_q;
  assign port_rsp_hs    = port_rsp_valid && port_rsp_ready;

  // Response to IR stage
  assign rsp_valid = ((state_q == F_RSP) && port_rsp_valid && !discard_q)
                     || (state_q == F_MIS);
  assign rsp_done    = rsp_valid && ir_ready;
  assign rsp.pc      = pc_q;
  assign rsp.buserr  = (state_q == F_RSP) && port_rsp_err;
  assign rsp.misalgn = (state_q == F_MIS);
  assign rsp.instr   = (((state_q == F_RSP) && port_rsp_err) || (state_q == F_MIS))
                       ? '0 : port_rsp_rdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= F_IDLE;
      discard_q <= 1'b0;
    end else begin
      unique case (state_q)
        F_IDLE: if (req_fire) state_q <= req.misalgn ? F_MIS : F_CMD;
        F_CMD:  if (cmd_hs) state_q <= F_RSP;
        F_RSP:  if (port_rsp_hs) state_q <= F_IDLE;
        F_MIS:  if (ir_ready || flush) state_q <= F_IDLE;
      endcase
      if ((state_q == F_RSP) && port_rsp_hs) begin
        discard_q <= 1'b0;
      end else if (flush && ((state_q == F_CMD) || (state_q == F_RSP))) begin
        discard_q <= 1'b1;  // Response still to come
      end
    end
  end

  // Address and port of the fetch in flight
  always_ff @(posedge clk) begin
    if (req_fire) begin
      pc_q       <= req.pc;
      sel_itcm_q <= in_itcm;
    end
  end

endmodule

`default_nettype wire

/* src/ifu_minidec.sv */
/*
  Mini-decode
  Spots Bxx, JAL and JALR in a fetched word, pulls out the immediates
  and makes a static prediction so the next PC is ready with the response
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_minidec (
  input  wire ifu_pkg::instr_t instr,
  input  wire ifu_pkg::pc_t    pc,         // PC of instr
  input  wire ifu_pkg::xlen_t  rf2ifu_x1,  // Current x1 value
  output ifu_pkg::prdt_t       prdt,
  output ifu_pkg::rfidx_t      rs1idx,
  output ifu_pkg::rfidx_t      rs2idx
);

  ifu_pkg::opcode_t opcode;
  logic             is_bxx;
  logic             is_jal;
  logic             is_jalr;
  logic             jalr_x0;
  logic             jalr_x1;
  ifu_pkg::pc_t     imm_b;
  ifu_pkg::pc_t     imm_j;
  ifu_pkg::pc_t     imm_i;
  ifu_pkg::pc_t     jalr_base;
  ifu_pkg::pc_t     jalr_sum;

  assign opcode = instr[6:0];
  assign rs1idx = instr[19:15];
  assign rs2idx = instr[24:20];

  assign is_bxx  = (opcode == ifu_pkg::OPC_BRANCH);
  assign is_jal  = (opcode == ifu_pkg::OPC_JAL);
  assign is_jalr = (opcode == ifu_pkg::OPC_JALR);

  // Sign-extended immediates
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_i = {{21{instr[31]}}, instr[30:20]};

  // Only x0 and x1 bases are predicted, others go sequential
  assign jalr_x0   = (rs1idx == 5'd0);
  assign jalr_x1   = (rs1idx == 5'd1);
  assign jalr_base = jalr_x1 ? rf2ifu_x1 : '0;
  assign jalr_sum  = jalr_base + imm_i;

  always_comb begin
    prdt.is_branch = is_bxx || is_jal || is_jalr;
    prdt.taken     = is_jal                                // Always taken
                     || (is_bxx && instr[31])              // Backward Bxx
                     || (is_jalr && (jalr_x0 || jalr_x1));
    if (is_jalr) begin
      prdt.target = {jalr_sum[31:1], 1'b0};  // JALR clears bit 0
    end else if (is_jal) begin
      prdt.target = pc + imm_j;
    end else begin
      prdt.target = pc + imm_b;
    end
  end

endmodule

`default_nettype wire

/* src/ifu_pcgen.sv */
/*
  PC generation stage
  Holds the fetch PC and hands one request at a time to the fetch port.
  Next PC is the reset vector, a flush target, the predicted target or
  the sequential address. Also answers the flush and halt requests
*/
`timescale 1ns/1ps
`default_nettype none

module ifu_pcgen (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire ifu_pkg::pc_t        pc_rtvec,           // Reset vector
  input  wire logic                rsp_done,           // Fetch handed to IR stage
  input  wire ifu_pkg::fetch_rsp_t rsp,
  input  wire ifu_pkg::prdt_t      prdt,               // Prediction for rsp
  input  wire logic                req_ready,
  input  wire logic                cmd_pending,        // Bus cmd waiting on ready
  input  wire logic                pipe_flush_req,
  input  wire ifu_pkg::pc_t        pipe_flush_add_op1,
  input  wire ifu_pkg::pc_t        pipe_flush_add_op2,
  input  wire logic                ifu_halt_req,
  input  wire logic                fetch_idle,         // Nothing outstanding
  output logic                     req_valid,
  output ifu_pkg::fetch_req_t      req,
  output logic                     pipe_flush_ack,
  output logic                     ifu_halt_ack
);

  typedef enum logic [1:0] {
    S_RESET,  // First cycle, PC taken from reset vector
    S_ISSUE,  // Request offered to fetch port
    S_WAIT,   // One fetch in flight
    S_STOP    // Misaligned fetch seen, wait for flush
  } state_t;

  state_t       state_q;
  ifu_pkg::pc_t pc_q;
  ifu_pkg::pc_t cur_pc;
  ifu_pkg::pc_t next_pc;
  logic         req_fire;
  logic         halt_ack_q;

  assign cur_pc = (state_q == S_RESET) ? pc_rtvec : pc_q;

  // Halt and a pending flush both hold off new requests
  assign req_valid = ((state_q == S_RESET) || (state_q == S_ISSUE))
                     && !ifu_halt_req && !pipe_flush_req;
  assign req.pc      = cur_pc;
  assign req.misalgn = |cur_pc[1:0];
  assign req_fire    = req_valid && req_ready;

  // Predicted target or fall through
  assign next_pc = prdt.taken ? prdt.target : (rsp.pc + ifu_pkg::PC_INCR);

  // No ack while a command sits on a bus, nor before the PC is loaded
  assign pipe_flush_ack = pipe_flush_req && !cmd_pending && (state_q != S_RESET);
  assign ifu_halt_ack   = halt_ack_q && ifu_halt_req;

  //////////////////////////////
  // State
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_RESET;
    end else if (pipe_flush_ack) begin
      state_q <= S_ISSUE;  // Flush wins over everything
    end else begin
      unique case (state_q)
        S_RESET: state_q <= req_fire ? S_WAIT : S_ISSUE;
        S_ISSUE: if (req_fire) state_q <= S_WAIT;
        S_WAIT:  if (rsp_done) state_q <= rsp.misalgn ? S_STOP : S_ISSUE;
        S_STOP:  state_q <= S_STOP;
      endcase
    end
  end

  // PC register
  always_ff @(posedge clk) begin
    if (pipe_flush_ack) begin
      pc_q <= pipe_flush_add_op1 + pipe_flush_add_op2;
    end else if (state_q == S_RESET) begin
      pc_q <= pc_rtvec;
    end else if ((state_q == S_WAIT) && rsp_done) begin
      pc_q <= next_pc;
    end
  end

  // Halt ack once the fetch port has drained
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_ack_q <= 1'b0;
    end else begin
      halt_ack_q <= ifu_halt_req && fetch_idle;
    end
  end

endmodule

`default_nettype wire

/* src/ifu_pkg.sv */
/*
  Instruction fetch unit shared definitions
  Widths, vector types, RV32 opcodes used by the mini-decode and the
  packed records passed between PC generation, fetch port and IR stage
*/
`default_nettype none

package ifu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int PC_W            = 32;
  localparam int INSTR_W         = 32;
  localparam int RFIDX_W         = 5;
  localparam int XLEN            = 32;
  localparam int ITCM_AW_DEFAULT = 16;  // 64 KiB ITCM window

  typedef logic [PC_W-1:0]    pc_t;     // PC or fetch address
  typedef logic [INSTR_W-1:0] instr_t;  // One 32-bit instruction word
  typedef logic [RFIDX_W-1:0] rfidx_t;  // Register file index
  typedef logic [XLEN-1:0]    xlen_t;   // Register value
  typedef logic [6:0]         opcode_t; // Major opcode field

  // Sequential step, no compressed instructions
  localparam pc_t PC_INCR = 32'd4;

  //////////////////////////////
  // Opcodes seen by mini-decode
  //////////////////////////////
  localparam opcode_t OPC_BRANCH = 7'b1100011; // Bxx
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;

  //////////////////////////////
  // Stage records
  //////////////////////////////

  // PC generation to fetch port
  typedef struct packed {
    pc_t  pc;
    logic misalgn;  // Low two PC bits nonzero
  } fetch_req_t;

  // Fetch port to IR stage and mini-decode
  typedef struct packed {
    pc_t    pc;
    instr_t instr;    // Zero on bus error or misalign
    logic   buserr;
    logic   misalgn;
  } fetch_rsp_t;

  // Static prediction result
  typedef struct packed {
    logic is_branch;  // Bxx, JAL or JALR
    logic taken;
    pc_t  target;
  } prdt_t;

endpackage

`default_nettype wire
